//--- tb/excp_cases.txt
// Hex columns: op a1..a6. op 1 write addr data, 2 read addr expected, 3 hwi level, 6 wait n
// op 4 request excp_valid ecode epc badv flush wr_pc, 5 check req_valid int_valid flush is, 0 end
2 0 8 0 0 0 0
2 5 0 0 0 0 0
2 6 0 0 0 0 0
2 42 0 0 0 0 0
1 c 1c001234 0 0 0 0
2 c 1c001200 0 0 0 0
1 88 8fff 0 0 0 0
2 88 8fc0 0 0 0 0
1 4 ffffffff 0 0 0 0
2 4 1bff 0 0 0 0
1 0 ffffffff 0 0 0 0
2 0 1ff 0 0 0 0
1 1 ff 0 0 0 0
2 1 7 0 0 0 0
1 11 deadbeef 0 0 0 0
2 11 deada000 0 0 0 0
// SYS from user mode with ie set
1 4 0 0 0 0 0
1 7 11111111 0 0 0 0
1 0 17 0 0 0 0
4 1 b 1c000100 22222222 1 1c001200
2 6 1c000100 0 0 0 0
2 5 b0000 0 0 0 0
2 1 7 0 0 0 0
2 0 10 0 0 0 0
2 7 11111111 0 0 0 0
4 0 0 1c000180 0 0 1c001200
// TLBR then PIL
4 1 3f 1c000200 12345678 1 8fc0
2 0 8 0 0 0 0
2 7 12345678 0 0 0 0
2 11 12344000 0 0 0 0
2 5 3f0000 0 0 0 0
1 0 10 0 0 0 0
4 1 1 1c000300 abcde123 1 1c001200
2 0 10 0 0 0 0
2 7 abcde123 0 0 0 0
2 11 abcde000 0 0 0 0
2 6 1c000300 0 0 0 0
// Hardware interrupt on hwi0
1 4 4 0 0 0 0
1 0 4 0 0 0 0
3 1 0 0 0 0 0
5 0 1 0 4 0 0
4 1 b 1c000400 0 1 1c001200
2 5 4 0 0 0 0
2 0 0 0 0 0 0
2 1 4 0 0 0 0
5 1 0 0 4 0 0
3 0 0 0 0 0 0
// Software interrupts
1 5 3 0 0 0 0
2 5 3 0 0 0 0
5 0 0 0 3 0 0
1 5 0 0 0 0 0
5 0 0 0 0 0 0
// Periodic timer, initval 8
1 41 b 0 0 0 0
2 42 8 0 0 0 0
6 8 0 0 0 0 0
5 0 0 0 800 0 0
6 14 0 0 0 0 0
5 0 0 0 800 0 0
1 41 0 0 0 0 0
1 44 1 0 0 0 0
5 0 0 0 0 0 0
2 42 0 0 0 0 0
0 0 0 0 0 0 0

//--- compile.f
verilog/excp_pkg.sv
verilog/excp_unit.sv
verilog/csr_file.sv
verilog/core_timer.sv
verilog/excp_subsys.sv
tb/excp_subsys_props.sv
tb/excp_subsys_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := excp_subsys_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
PASS_MSG := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/excp_subsys_tb.sv
`timescale 1ns/1ps

module excp_subsys_tb;

    localparam int rec_w     = 7;
    localparam int max_rec   = 128;
    localparam int rst_cycles = 2;
    localparam int margin    = 50;

    logic                            clk;
    logic                            rst_n;
    logic                            req_valid;
    logic                            excp_valid;
    logic [excp_pkg::ecode_w-1:0]    ecode;
    logic [31:0]                     epc;
    logic [31:0]                     badv;
    logic [excp_pkg::hwi_w-1:0]      hwi;
    logic                            csr_we;
    logic [excp_pkg::csr_addr_w-1:0] csr_addr;
    logic [31:0]                     csr_wdata;
    logic [31:0]                     csr_rdata;
    logic                            excp_flush;
    logic                            wr_pc_valid;
    logic [31:0]                     wr_pc;
    logic                            int_valid;
    logic [excp_pkg::int_w-1:0]      is;

    // One record is an opcode and six arguments
    logic [31:0] cases [0:rec_w*max_rec-1];
    int          cycle_cnt = 0;
    int          cycle_limit;
    int          n_checks;

    excp_subsys #(
        .timer_w (32)
    ) excp_subsys_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .excp_valid  (excp_valid),
        .ecode       (ecode),
        .epc         (epc),
        .badv        (badv),
        .hwi         (hwi),
        .csr_we      (csr_we),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .excp_flush  (excp_flush),
        .wr_pc_valid (wr_pc_valid),
        .wr_pc       (wr_pc),
        .int_valid   (int_valid),
        .is          (is)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_is(input string name, input logic [excp_pkg::int_w-1:0] got,
                            input logic [excp_pkg::int_w-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    // Runaway guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_with_failure($sformatf("timeout: run did not end within %0d cycles",
                                        cycle_limit));
        end
    end

    task automatic drive_idle();
        csr_we     = 1'b0;
        req_valid  = 1'b0;
        excp_valid = 1'b0;
    endtask

    // Each record owns one cycle, a wait record owns its count
    task automatic run_record(input int idx);
        logic [31:0] op;
        int          base;
        base = idx * rec_w;
        op   = cases[base];
        @(posedge clk);
        #1;
        drive_idle();
        case (op)
            32'd1: begin
                csr_we    = 1'b1;
                csr_addr  = cases[base+1][excp_pkg::csr_addr_w-1:0];
                csr_wdata = cases[base+2];
            end
            32'd2: begin
                csr_addr = cases[base+1][excp_pkg::csr_addr_w-1:0];
                @(negedge clk);
                check_word($sformatf("csr %h", csr_addr), csr_rdata, cases[base+2]);
            end
            32'd3: hwi = cases[base+1][excp_pkg::hwi_w-1:0];
            32'd4: begin
                req_valid  = 1'b1;
                excp_valid = cases[base+1][0];
                ecode      = cases[base+2][excp_pkg::ecode_w-1:0];
                epc        = cases[base+3];
                badv       = cases[base+4];
                @(negedge clk);
                check_bit("excp_flush", excp_flush, cases[base+5][0]);
                check_bit("wr_pc_valid", wr_pc_valid, cases[base+5][0]);
                check_word("wr_pc", wr_pc, cases[base+6]);
            end
            32'd5: begin
                req_valid = cases[base+1][0];
                @(negedge clk);
                check_bit("int_valid", int_valid, cases[base+2][0]);
                check_bit("excp_flush", excp_flush, cases[base+3][0]);
                check_is("is", is, cases[base+4][excp_pkg::int_w-1:0]);
            end
            32'd6: begin
                repeat (cases[base+1] - 1) begin
                    @(posedge clk);
                    #1;
                    drive_idle();
                end
            end
            default: stop_with_failure($sformatf("unknown record type %h in record %0d",
                                                 op, idx));
        endcase
    endtask

    initial begin
        int n_rec;
        int limit;
        rst_n       = 1'b0;
        hwi         = '0;
        ecode       = '0;
        epc         = '0;
        badv        = '0;
        csr_addr    = '0;
        csr_wdata   = '0;
        cycle_limit = 0;
        n_checks    = 0;
        drive_idle();
        $readmemh("tb/excp_cases.txt", cases);
        if (cases[0] === 'x) begin
            stop_with_failure("could not read the case file tb/excp_cases.txt");
        end
        n_rec = 0;
        limit = rst_cycles + margin;
        while (n_rec < max_rec && cases[n_rec*rec_w] !== 32'd0) begin
            if (cases[n_rec*rec_w] === 32'd6) begin
                limit += cases[n_rec*rec_w+1];
            end else begin
                limit += 1;
            end
            n_rec++;
        end
        if (n_rec == max_rec) begin
            stop_with_failure("the case file has no end record");
        end
        cycle_limit = limit;
        repeat (rst_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_rec; i++) begin
            run_record(i);
        end
        if (n_checks > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_with_failure("the case file held no checks");
        end
    end

endmodule

//--- tb/excp_subsys_props.sv
`timescale 1ns/1ps

module excp_subsys_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         req_valid,
    input logic                         excp_valid,
    input logic [excp_pkg::ecode_w-1:0] ecode,
    input logic                         int_valid,
    input logic [31:0]                  eentry,
    input logic [31:0]                  tlbrentry,
    input logic                         excp_flush,
    input logic                         wr_pc_valid,
    input logic [31:0]                  wr_pc,
    input logic                         commit_we,
    input logic                         ti_clr,
    input logic [excp_pkg::int_w-1:0]   is
);

    logic tlbr_taken;

    // An interrupt preempts a TLBR exception in the same cycle
    assign tlbr_taken = excp_valid && !int_valid && (ecode == excp_pkg::TLBR);

    flush_has_pc: assert property (@(posedge clk) disable iff (!rst_n)
        excp_flush |-> wr_pc_valid && wr_pc == (tlbr_taken ? tlbrentry : eentry))
        else $error("flush raised without the right PC redirect");

    commit_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        commit_we == (req_valid && (excp_valid || int_valid)))
        else $error("CSR commit does not match the request");

    // Clear wins over a timer pulse in the same cycle
    ti_clr_clears: assert property (@(posedge clk) disable iff (!rst_n)
        ti_clr |=> !is[excp_pkg::ti_bit])
        else $error("timer bit still pending after a TICLR write");

    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !excp_flush)
        else $error("flush in the first cycle after reset");

endmodule

bind excp_unit excp_subsys_props excp_subsys_props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .excp_valid  (excp_valid),
    .ecode       (ecode),
    .int_valid   (int_valid),
    .eentry      (eentry),
    .tlbrentry   (tlbrentry),
    .excp_flush  (excp_flush),
    .wr_pc_valid (wr_pc_valid),
    .wr_pc       (wr_pc),
    .commit_we   (commit_we),
    .ti_clr      (ti_clr),
    .is          (is)
);

//--- verilog/excp_subsys.sv
`timescale 1ns/1ps

module excp_subsys #(
    parameter int timer_w = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            req_valid,
    input  logic                            excp_valid,
    input  logic [excp_pkg::ecode_w-1:0]    ecode,
    input  logic [31:0]                     epc,
    input  logic [31:0]                     badv,
    input  logic [excp_pkg::hwi_w-1:0]      hwi,

    input  logic                            csr_we,
    input  logic [excp_pkg::csr_addr_w-1:0] csr_addr,
    input  logic [31:0]                     csr_wdata,
    output logic [31:0]                     csr_rdata,

    output logic                            excp_flush,
    output logic                            wr_pc_valid,
    output logic [31:0]                     wr_pc,
    output logic                            int_valid,
    output logic [excp_pkg::int_w-1:0]      is
);

    logic [excp_pkg::plv_w-1:0]   crmd_plv;
    logic                         crmd_ie;
    logic [excp_pkg::int_w-1:0]   ecfg_lie;
    logic [31:0]                  eentry;
    logic [31:0]                  tlbrentry;
    logic [1:0]                   swi_set;
    logic [1:0]                   swi_clr;
    logic                         ti_clr;
    logic                         tcfg_we;
    logic [31:0]                  tcfg_wdata;
    logic                         ti;
    logic [31:0]                  tval;
    logic                         commit_we;
    logic [excp_pkg::plv_w-1:0]   commit_plv_prev;
    logic                         commit_ie_prev;
    logic [excp_pkg::ecode_w-1:0] commit_ecode;
    logic [31:0]                  commit_era;
    logic                         commit_tlbr;
    logic                         commit_badv_we;
    logic                         commit_tlbehi_we;
    logic [31:0]                  commit_badv;

    excp_unit excp_unit_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .excp_valid       (excp_valid),
        .ecode            (ecode),
        .epc              (epc),
        .badv             (badv),
        .hwi              (hwi),
        .swi_set          (swi_set),
        .swi_clr          (swi_clr),
        .ti               (ti),
        .ti_clr           (ti_clr),
        .crmd_plv         (crmd_plv),
        .crmd_ie          (crmd_ie),
        .ecfg_lie         (ecfg_lie),
        .eentry           (eentry),
        .tlbrentry        (tlbrentry),
        .is               (is),
        .int_valid        (int_valid),
        .excp_flush       (excp_flush),
        .wr_pc_valid      (wr_pc_valid),
        .wr_pc            (wr_pc),
        .commit_we        (commit_we),
        .commit_plv_prev  (commit_plv_prev),
        .commit_ie_prev   (commit_ie_prev),
        .commit_ecode     (commit_ecode),
        .commit_era       (commit_era),
        .commit_tlbr      (commit_tlbr),
        .commit_badv_we   (commit_badv_we),
        .commit_tlbehi_we (commit_tlbehi_we),
        .commit_badv      (commit_badv)
    );

    csr_file csr_file_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .csr_we           (csr_we),
        .csr_addr         (csr_addr),
        .csr_wdata        (csr_wdata),
        .csr_rdata        (csr_rdata),
        .is               (is),
        .tval             (tval),
        .commit_we        (commit_we),
        .commit_plv_prev  (commit_plv_prev),
        .commit_ie_prev   (commit_ie_prev),
        .commit_ecode     (commit_ecode),
        .commit_era       (commit_era),
        .commit_tlbr      (commit_tlbr),
        .commit_badv_we   (commit_badv_we),
        .commit_tlbehi_we (commit_tlbehi_we),
        .commit_badv      (commit_badv),
        .crmd_plv         (crmd_plv),
        .crmd_ie          (crmd_ie),
        .ecfg_lie         (ecfg_lie),
        .eentry           (eentry),
        .tlbrentry        (tlbrentry),
        .swi_set          (swi_set),
        .swi_clr          (swi_clr),
        .ti_clr           (ti_clr),
        .tcfg_we          (tcfg_we),
        .tcfg_wdata       (tcfg_wdata)
    );

    core_timer #(
        .timer_w (timer_w)
    ) core_timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tcfg_we    (tcfg_we),
        .tcfg_wdata (tcfg_wdata),
        .ti         (ti),
        .tval       (tval)
    );

endmodule

//--- verilog/core_timer.sv
`timescale 1ns/1ps

module core_timer #(
    parameter int timer_w = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tcfg_we,
    input  logic [31:0] tcfg_wdata,
    output logic        ti,
    output logic [31:0] tval
);

    logic               en;
    logic               periodic;
    logic [timer_w-1:0] initval;
    logic [timer_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
            cnt      <= '0;
        end else if (tcfg_we) begin
            en       <= tcfg_wdata[0];
            periodic <= tcfg_wdata[1];
            // Initval is word aligned, low two bits hold the mode
            initval  <= {tcfg_wdata[timer_w-1:2], 2'b00};
            cnt      <= {tcfg_wdata[timer_w-1:2], 2'b00};
        end else if (en) begin
            if (cnt == '0) begin
                if (periodic) begin
                    cnt <= initval;
                end else begin
                    en <= 1'b0;
                end
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign ti   = en & (cnt == '0);
    assign tval = 32'(cnt);

endmodule

//--- verilog/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                            clk,
    input  logic                            rst_n,

    // Software port
    input  logic                            csr_we,
    input  logic [excp_pkg::csr_addr_w-1:0] csr_addr,
    input  logic [31:0]                     csr_wdata,
    output logic [31:0]                     csr_rdata,

    input  logic [excp_pkg::int_w-1:0]      is,
    input  logic [31:0]                     tval,

    // Exception commit
    input  logic                            commit_we,
    input  logic [excp_pkg::plv_w-1:0]      commit_plv_prev,
    input  logic                            commit_ie_prev,
    input  logic [excp_pkg::ecode_w-1:0]    commit_ecode,
    input  logic [31:0]                     commit_era,
    input  logic                            commit_tlbr,
    input  logic                            commit_badv_we,
    input  logic                            commit_tlbehi_we,
    input  logic [31:0]                     commit_badv,

    output logic [excp_pkg::plv_w-1:0]      crmd_plv,
    output logic                            crmd_ie,
    output logic [excp_pkg::int_w-1:0]      ecfg_lie,
    output logic [31:0]                     eentry,
    output logic [31:0]                     tlbrentry,
    output logic [1:0]                      swi_set,
    output logic [1:0]                      swi_clr,
    output logic                            ti_clr,
    output logic                            tcfg_we,
    output logic [31:0]                     tcfg_wdata
);

    logic                           crmd_da;
    logic                           crmd_pg;
    logic [1:0]                     crmd_datf;
    logic [1:0]                     crmd_datm;
    logic [excp_pkg::plv_w-1:0]     prmd_pplv;
    logic                           prmd_pie;
    logic [excp_pkg::ecode_w-1:0]   estat_cause;
    logic [31:0]                    era;
    logic [31:0]                    badv_r;
    logic [25:0]                    eentry_va;
    logic [25:0]                    tlbrentry_pa;
    logic [18:0]                    tlbehi_vppn;
    logic [31:0]                    tcfg;
    logic                           wr_estat;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_plv     <= excp_pkg::KERNEL;
            crmd_ie      <= 1'b0;
            crmd_da      <= 1'b1;
            crmd_pg      <= 1'b0;
            crmd_datf    <= 2'b00;
            crmd_datm    <= 2'b00;
            prmd_pplv    <= '0;
            prmd_pie     <= 1'b0;
            ecfg_lie     <= '0;
            estat_cause  <= '0;
            era          <= '0;
            badv_r       <= '0;
            eentry_va    <= '0;
            tlbrentry_pa <= '0;
            tlbehi_vppn  <= '0;
            tcfg         <= '0;
        end else begin
            if (csr_we) begin
                case (csr_addr)
                    excp_pkg::CSR_CRMD: begin
                        crmd_plv  <= csr_wdata[1:0];
                        crmd_ie   <= csr_wdata[2];
                        crmd_da   <= csr_wdata[3];
                        crmd_pg   <= csr_wdata[4];
                        crmd_datf <= csr_wdata[6:5];
                        crmd_datm <= csr_wdata[8:7];
                    end
                    excp_pkg::CSR_PRMD: begin
                        prmd_pplv <= csr_wdata[1:0];
                        prmd_pie  <= csr_wdata[2];
                    end
                    excp_pkg::CSR_ECFG:      ecfg_lie     <= csr_wdata[12:0] & excp_pkg::ecfg_lie_mask;
                    excp_pkg::CSR_ERA:       era          <= csr_wdata;
                    excp_pkg::CSR_BADV:      badv_r       <= csr_wdata;
                    excp_pkg::CSR_EENTRY:    eentry_va    <= csr_wdata[31:6];
                    excp_pkg::CSR_TLBRENTRY: tlbrentry_pa <= csr_wdata[31:6];
                    excp_pkg::CSR_TLBEHI:    tlbehi_vppn  <= csr_wdata[31:13];
                    excp_pkg::CSR_TCFG:      tcfg         <= csr_wdata;
                    default: ;
                endcase
            end
            // Commit comes last so it overrides a software write
            if (commit_we) begin
                crmd_plv    <= excp_pkg::KERNEL;
                crmd_ie     <= 1'b0;
                prmd_pplv   <= commit_plv_prev;
                prmd_pie    <= commit_ie_prev;
                era         <= commit_era;
                estat_cause <= commit_ecode;
                if (commit_tlbr) begin
                    crmd_da <= 1'b1;
                    crmd_pg <= 1'b0;
                end
                if (commit_badv_we) begin
                    badv_r <= commit_badv;
                end
                if (commit_tlbehi_we) begin
                    tlbehi_vppn <= commit_badv[31:13];
                end
            end
        end
    end

    assign eentry    = {eentry_va, 6'b0};
    assign tlbrentry = {tlbrentry_pa, 6'b0};

    always_comb begin
        case (csr_addr)
            excp_pkg::CSR_CRMD:
                csr_rdata = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
            excp_pkg::CSR_PRMD:      csr_rdata = {29'b0, prmd_pie, prmd_pplv};
            excp_pkg::CSR_ECFG:      csr_rdata = {19'b0, ecfg_lie};
            excp_pkg::CSR_ESTAT:     csr_rdata = {1'b0, estat_cause, 3'b0, is};
            excp_pkg::CSR_ERA:       csr_rdata = era;
            excp_pkg::CSR_BADV:      csr_rdata = badv_r;
            excp_pkg::CSR_EENTRY:    csr_rdata = eentry;
            excp_pkg::CSR_TLBRENTRY: csr_rdata = tlbrentry;
            excp_pkg::CSR_TLBEHI:    csr_rdata = {tlbehi_vppn, 13'b0};
            excp_pkg::CSR_TCFG:      csr_rdata = tcfg;
            excp_pkg::CSR_TVAL:      csr_rdata = tval;
            default:                 csr_rdata = 32'b0;
        endcase
    end

    // ESTAT writes drive the two software interrupt bits directly
    assign wr_estat = csr_we & (csr_addr == excp_pkg::CSR_ESTAT);
    assign swi_set  = wr_estat ? csr_wdata[1:0] : 2'b00;
    assign swi_clr  = wr_estat ? ~csr_wdata[1:0] : 2'b00;

    assign ti_clr     = csr_we & (csr_addr == excp_pkg::CSR_TICLR) & csr_wdata[0];
    assign tcfg_we    = csr_we & (csr_addr == excp_pkg::CSR_TCFG);
    assign tcfg_wdata = csr_wdata;

endmodule

//--- verilog/excp_unit.sv
`timescale 1ns/1ps

module excp_unit (
    input  logic                         clk,
    input  logic                         rst_n,

    // Memory stage request
    input  logic                         req_valid,
    input  logic                         excp_valid,
    input  logic [excp_pkg::ecode_w-1:0] ecode,
    input  logic [31:0]                  epc,
    input  logic [31:0]                  badv,

    // Interrupt sources
    input  logic [excp_pkg::hwi_w-1:0]   hwi,
    input  logic [1:0]                   swi_set,
    input  logic [1:0]                   swi_clr,
    input  logic                         ti,
    input  logic                         ti_clr,

    // Current CSR state
    input  logic [excp_pkg::plv_w-1:0]   crmd_plv,
    input  logic                         crmd_ie,
    input  logic [excp_pkg::int_w-1:0]   ecfg_lie,
    input  logic [31:0]                  eentry,
    input  logic [31:0]                  tlbrentry,

    output logic [excp_pkg::int_w-1:0]   is,
    output logic                         int_valid,
    output logic                         excp_flush,
    output logic                         wr_pc_valid,
    output logic [31:0]                  wr_pc,

    // Commit towards the CSR file
    output logic                         commit_we,
    output logic [excp_pkg::plv_w-1:0]   commit_plv_prev,
    output logic                         commit_ie_prev,
    output logic [excp_pkg::ecode_w-1:0] commit_ecode,
    output logic [31:0]                  commit_era,
    output logic                         commit_tlbr,
    output logic                         commit_badv_we,
    output logic                         commit_tlbehi_we,
    output logic [31:0]                  commit_badv
);

    logic [1:0] swi_r;
    logic       ti_r;
    logic       is_int;
    logic       is_excp;
    logic       is_tlbr;
    logic       wr_badv;
    logic       wr_tlbehi;

    // Latched software and timer lines, clear beats set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            swi_r <= 2'b00;
            ti_r  <= 1'b0;
        end else begin
            swi_r <= ~swi_clr & (swi_set | swi_r);
            ti_r  <= ~ti_clr & (ti | ti_r);
        end
    end

    // No IPI line, bit 10 unused
    assign is = {1'b0, ti_r, 1'b0, hwi, swi_r};

    // Also serves as the idle wakeup level
    assign int_valid = crmd_ie & (|(is & ecfg_lie));

    assign is_int  = req_valid & int_valid;
    assign is_excp = req_valid & excp_valid & ~is_int;
    assign is_tlbr = is_excp & (ecode == excp_pkg::TLBR);

    assign excp_flush  = is_int | is_excp;
    assign wr_pc_valid = excp_flush;
    assign wr_pc       = is_tlbr ? tlbrentry : eentry;

    // Address and page faults carry a bad address
    assign wr_badv = ecode inside {excp_pkg::TLBR, excp_pkg::ADEF, excp_pkg::ADEM,
                                   excp_pkg::ALE, excp_pkg::PIL, excp_pkg::PIS,
                                   excp_pkg::PIF, excp_pkg::PME, excp_pkg::PPI};

    assign wr_tlbehi = ecode inside {excp_pkg::TLBR, excp_pkg::PIL, excp_pkg::PIS,
                                     excp_pkg::PIF, excp_pkg::PME, excp_pkg::PPI};

    assign commit_we        = excp_flush;
    assign commit_plv_prev  = crmd_plv;
    assign commit_ie_prev   = crmd_ie;
    assign commit_ecode     = is_int ? excp_pkg::INT : ecode;
    assign commit_era       = epc;
    assign commit_tlbr      = is_tlbr;
    assign commit_badv_we   = is_excp & wr_badv;
    assign commit_tlbehi_we = is_excp & wr_tlbehi;
    assign commit_badv      = badv;

endmodule

//--- verilog/excp_pkg.sv
package excp_pkg;

    // Field widths
    localparam int ecode_w    = 15;
    localparam int int_w      = 13;
    localparam int hwi_w      = 8;
    localparam int csr_addr_w = 14;
    localparam int plv_w      = 2;

    // Position of the timer bit in the pending vector
    localparam int ti_bit = 11;

    // Bit 10 of LIE is reserved
    localparam logic [int_w-1:0] ecfg_lie_mask = 13'h1bff;

    // Combined {esubcode, ecode}
    localparam logic [ecode_w-1:0] INT  = 15'h0000;
    localparam logic [ecode_w-1:0] PIL  = 15'h0001;
    localparam logic [ecode_w-1:0] PIS  = 15'h0002;
    localparam logic [ecode_w-1:0] PIF  = 15'h0003;
    localparam logic [ecode_w-1:0] PME  = 15'h0004;
    localparam logic [ecode_w-1:0] PPI  = 15'h0007;
    localparam logic [ecode_w-1:0] ADEF = 15'h0008;
    localparam logic [ecode_w-1:0] ADEM = 15'h0048;
    localparam logic [ecode_w-1:0] ALE  = 15'h0009;
    localparam logic [ecode_w-1:0] SYS  = 15'h000b;
    localparam logic [ecode_w-1:0] BRK  = 15'h000c;
    localparam logic [ecode_w-1:0] INE  = 15'h000d;
    localparam logic [ecode_w-1:0] TLBR = 15'h003f;

    localparam logic [plv_w-1:0] KERNEL = 2'd0;
    localparam logic [plv_w-1:0] USER   = 2'd3;

    localparam logic [csr_addr_w-1:0] CSR_CRMD      = 14'h000;
    localparam logic [csr_addr_w-1:0] CSR_PRMD      = 14'h001;
    localparam logic [csr_addr_w-1:0] CSR_ECFG      = 14'h004;
    localparam logic [csr_addr_w-1:0] CSR_ESTAT     = 14'h005;
    localparam logic [csr_addr_w-1:0] CSR_ERA       = 14'h006;
    localparam logic [csr_addr_w-1:0] CSR_BADV      = 14'h007;
    localparam logic [csr_addr_w-1:0] CSR_EENTRY    = 14'h00c;
    localparam logic [csr_addr_w-1:0] CSR_TLBEHI    = 14'h011;
    localparam logic [csr_addr_w-1:0] CSR_TCFG      = 14'h041;
    localparam logic [csr_addr_w-1:0] CSR_TVAL      = 14'h042;
    localparam logic [csr_addr_w-1:0] CSR_TICLR     = 14'h044;
    localparam logic [csr_addr_w-1:0] CSR_TLBRENTRY = 14'h088;

endpackage
